// File: hdl/riscv_defines.svh
// Widths, reset fetch address and instruction field positions; include wherever they are needed
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// Datapath and address width
`define RISCV_XLEN      32
`define RISCV_PC_INIT   32'h0000_0200   // First fetch address after reset
`define RISCV_REG_BITS  5               // Register index width
`define RISCV_INSN_BITS 32

// Instruction field positions, LSB of each field
`define RISCV_OPC_BITS  7
`define RISCV_RD_LSB    7
`define RISCV_F3_LSB    12
`define RISCV_RS1_LSB   15
`define RISCV_RS2_LSB   20
`define RISCV_F7_LSB    25

`endif

// File: hdl/riscv_pkg.sv
// Opcode and ALU enums plus the pipeline structs, referenced by scoped names
`include "riscv_defines.svh"

package riscv_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [`RISCV_OPC_BITS-1:0]
  {
    OP_LUI   = 7'b0110111,
    OP_IMM   = 7'b0010011,
    OP_REG   = 7'b0110011,
    OP_STORE = 7'b0100011
  } opcode_t;

  typedef enum logic [2:0]
  {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASSB   // Operand B straight through, used by LUI
  } alu_op_t;

  //////////////////////////////
  // Fetch to decode
  typedef struct packed
  {
    logic [`RISCV_INSN_BITS-1:0] insn;
    logic [`RISCV_XLEN-1:0]      pc;
    logic                        bubble;   // No instruction this cycle
  } fetch_t;

  //////////////////////////////
  // Execute to write-back
  typedef struct packed
  {
    logic                       we;      // Register write
    logic [`RISCV_REG_BITS-1:0] dst;
    logic [`RISCV_XLEN-1:0]     r;       // ALU result or store address
    logic                       store;
    logic [`RISCV_XLEN-1:0]     sd;      // Store data
  } wb_t;

endpackage

// File: hdl/riscv_if.sv
// Fetch stage: holds the PC, requests words on the instruction bus and registers them downstream
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_if
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  // Instruction bus
  output logic [`RISCV_XLEN-1:0]       imem_adr_o,
  output logic                         imem_req_o,
  input  logic                         imem_ack_i,
  input  logic [`RISCV_INSN_BITS-1:0]  imem_parcel_i,

  output riscv_pkg::fetch_t            if_fetch_o
);

  logic [`RISCV_XLEN-1:0]      pc;
  logic                        req;
  logic                        fetched;     // Word taken this cycle
  logic                        bubble_q;
  logic [`RISCV_INSN_BITS-1:0] insn_q;
  logic [`RISCV_XLEN-1:0]      pc_q;

  assign fetched = req & imem_ack_i;

  // PC and request
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pc       <= `RISCV_PC_INIT;
      req      <= 1'b0;
      bubble_q <= 1'b1;
    end
    else
    begin
      req      <= 1'b1;            // Request continuously once out of reset
      bubble_q <= ~fetched;
      if (fetched)
        pc <= pc + 'd4;
    end
  end

  // Instruction word and its address
  always_ff @(posedge clk_i)
  begin
    insn_q <= imem_parcel_i;
    pc_q   <= pc;
  end

  assign imem_adr_o = pc;
  assign imem_req_o = req;

  assign if_fetch_o = '{insn: insn_q, pc: pc_q, bubble: bubble_q};

endmodule

// File: hdl/riscv_rf.sv
// Integer register file: two combinational read ports, one write port, x0 hardwired to zero
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_rf
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  logic [`RISCV_REG_BITS-1:0] rf_src1_i,
  input  logic [`RISCV_REG_BITS-1:0] rf_src2_i,
  output logic [`RISCV_XLEN-1:0]     rf_src1_q_o,
  output logic [`RISCV_XLEN-1:0]     rf_src2_q_o,

  input  logic [`RISCV_REG_BITS-1:0] rf_dst_i,
  input  logic [`RISCV_XLEN-1:0]     rf_dst_d_i,
  input  logic                       rf_we_i
);

  logic [`RISCV_XLEN-1:0] regs [1:31];   // x1..x31

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (rf_we_i && rf_dst_i != '0)    // Writes to x0 dropped
      regs[rf_dst_i] <= rf_dst_d_i;
  end

  assign rf_src1_q_o = (rf_src1_i == '0) ? '0 : regs[rf_src1_i];
  assign rf_src2_q_o = (rf_src2_i == '0) ? '0 : regs[rf_src2_i];

endmodule

// File: hdl/riscv_id_ex.sv
// Decode and execute: decodes the subset, bypasses the write-back value and registers the result
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_id_ex
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  riscv_pkg::fetch_t          if_fetch_i,

  // Register file read
  output logic [`RISCV_REG_BITS-1:0] rf_src1_o,
  output logic [`RISCV_REG_BITS-1:0] rf_src2_o,
  input  logic [`RISCV_XLEN-1:0]     rf_src1_q_i,
  input  logic [`RISCV_XLEN-1:0]     rf_src2_q_i,

  // Bypass from write-back
  input  logic                       wb_we_i,
  input  logic [`RISCV_REG_BITS-1:0] wb_dst_i,
  input  logic [`RISCV_XLEN-1:0]     wb_r_i,

  output riscv_pkg::wb_t             ex_wb_o
);

  logic [`RISCV_INSN_BITS-1:0] insn;
  logic [`RISCV_REG_BITS-1:0]  rs1, rs2, rd;
  logic [2:0]                  funct3;
  logic [6:0]                  funct7;
  logic [`RISCV_XLEN-1:0]      imm_i, imm_s, imm_u, imm;
  riscv_pkg::opcode_t          opc;
  riscv_pkg::alu_op_t          alu_op;
  logic                        valid, is_store, use_rs2;
  logic [`RISCV_XLEN-1:0]      src1, src2, opb, alu_r;
  logic                        ex_we, ex_store;
  logic [`RISCV_REG_BITS-1:0]  ex_dst;
  logic [`RISCV_XLEN-1:0]      ex_r, ex_sd;

  //////////////////////////////
  // Fields and immediates
  assign insn   = if_fetch_i.insn;
  assign rs1    = insn[`RISCV_RS1_LSB +: `RISCV_REG_BITS];
  assign rs2    = insn[`RISCV_RS2_LSB +: `RISCV_REG_BITS];
  assign rd     = insn[`RISCV_RD_LSB  +: `RISCV_REG_BITS];
  assign funct3 = insn[`RISCV_F3_LSB  +: 3];
  assign funct7 = insn[`RISCV_F7_LSB  +: 7];
  assign opc    = riscv_pkg::opcode_t'(insn[`RISCV_OPC_BITS-1:0]);

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_u = {insn[31:12], 12'h000};

  always_comb
  begin
    alu_op   = riscv_pkg::ALU_ADD;
    imm      = imm_i;
    valid    = 1'b1;
    is_store = 1'b0;
    use_rs2  = 1'b0;
    case (opc)
      riscv_pkg::OP_LUI:
      begin
        alu_op = riscv_pkg::ALU_PASSB;
        imm    = imm_u;
      end
      riscv_pkg::OP_IMM:
        case (funct3)
          3'b000:  alu_op = riscv_pkg::ALU_ADD;
          3'b111:  alu_op = riscv_pkg::ALU_AND;
          3'b110:  alu_op = riscv_pkg::ALU_OR;
          3'b100:  alu_op = riscv_pkg::ALU_XOR;
          default: valid  = 1'b0;
        endcase
      riscv_pkg::OP_REG:
      begin
        use_rs2 = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = riscv_pkg::ALU_ADD;
          10'b0100000_000: alu_op = riscv_pkg::ALU_SUB;
          10'b0000000_111: alu_op = riscv_pkg::ALU_AND;
          10'b0000000_110: alu_op = riscv_pkg::ALU_OR;
          10'b0000000_100: alu_op = riscv_pkg::ALU_XOR;
          default:         valid  = 1'b0;
        endcase
      end
      riscv_pkg::OP_STORE:
      begin
        imm      = imm_s;              // Address is rs1 + imm
        valid    = (funct3 == 3'b010); // SW only
        is_store = 1'b1;
      end
      default: valid = 1'b0;
    endcase
    if (if_fetch_i.bubble)
      valid = 1'b0;
  end

  //////////////////////////////
  // Operands with bypass
  assign rf_src1_o = rs1;
  assign rf_src2_o = rs2;

  assign src1 = (wb_we_i && wb_dst_i == rs1 && rs1 != '0) ? wb_r_i : rf_src1_q_i;
  assign src2 = (wb_we_i && wb_dst_i == rs2 && rs2 != '0) ? wb_r_i : rf_src2_q_i;
  assign opb  = use_rs2 ? src2 : imm;

  always_comb
  begin
    case (alu_op)
      riscv_pkg::ALU_ADD: alu_r = src1 + opb;
      riscv_pkg::ALU_SUB: alu_r = src1 - opb;
      riscv_pkg::ALU_AND: alu_r = src1 & opb;
      riscv_pkg::ALU_OR:  alu_r = src1 | opb;
      riscv_pkg::ALU_XOR: alu_r = src1 ^ opb;
      default:            alu_r = opb;
    endcase
  end

  //////////////////////////////
  // Execute pipeline register
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ex_we    <= 1'b0;
      ex_store <= 1'b0;
    end
    else
    begin
      ex_we    <= valid & ~is_store;
      ex_store <= valid & is_store;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ex_dst <= rd;
    ex_r   <= alu_r;
    ex_sd  <= src2;     // Store data, bypassed as well
  end

  assign ex_wb_o = '{we: ex_we, dst: ex_dst, r: ex_r, store: ex_store, sd: ex_sd};

endmodule

// File: hdl/riscv_wb.sv
// Write-back stage: splits the execute result into the register write port and the data bus
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_wb
(
  input  riscv_pkg::wb_t             wb_i,

  // Register file write
  output logic [`RISCV_REG_BITS-1:0] rf_dst_o,
  output logic [`RISCV_XLEN-1:0]     rf_dst_d_o,
  output logic                       rf_we_o,

  // Data bus
  output logic [`RISCV_XLEN-1:0]     dmem_adr_o,
  output logic [`RISCV_XLEN-1:0]     dmem_d_o,
  output logic                       dmem_we_o,

  // Bypass back to decode
  output logic                       wb_we_o,
  output logic [`RISCV_REG_BITS-1:0] wb_dst_o,
  output logic [`RISCV_XLEN-1:0]     wb_r_o
);

  assign rf_we_o    = wb_i.we;
  assign rf_dst_o   = wb_i.dst;
  assign rf_dst_d_o = wb_i.r;

  // Word stores only
  assign dmem_we_o  = wb_i.store;
  assign dmem_adr_o = {wb_i.r[`RISCV_XLEN-1:2], 2'b00};
  assign dmem_d_o   = wb_i.sd;

  assign wb_we_o    = wb_i.we;      // Same value the register file takes
  assign wb_dst_o   = wb_i.dst;
  assign wb_r_o     = wb_i.r;

endmodule

// File: hdl/riscv_core.sv
// Core top level: connects fetch, decode/execute, write-back and the register file
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_core
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // Instruction bus
  output logic [`RISCV_XLEN-1:0]      imem_adr_o,
  output logic                        imem_req_o,
  input  logic                        imem_ack_i,
  input  logic [`RISCV_INSN_BITS-1:0] imem_parcel_i,

  // Data bus, stores only
  output logic [`RISCV_XLEN-1:0]      dmem_adr_o,
  output logic [`RISCV_XLEN-1:0]      dmem_d_o,
  output logic                        dmem_we_o
);

  riscv_pkg::fetch_t          if_fetch;
  riscv_pkg::wb_t             ex_wb;
  logic [`RISCV_REG_BITS-1:0] rf_src1, rf_src2, rf_dst, wb_dst;
  logic [`RISCV_XLEN-1:0]     rf_srcv1, rf_srcv2, rf_dst_d, wb_r;
  logic                       rf_we, wb_we;

  riscv_if if_unit
  (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .imem_adr_o    ( imem_adr_o    ),
    .imem_req_o    ( imem_req_o    ),
    .imem_ack_i    ( imem_ack_i    ),
    .imem_parcel_i ( imem_parcel_i ),
    .if_fetch_o    ( if_fetch      )
  );

  riscv_id_ex ex_unit
  (
    .clk_i       ( clk_i    ),
    .rst_n_i     ( rst_n_i  ),
    .if_fetch_i  ( if_fetch ),
    .rf_src1_o   ( rf_src1  ),
    .rf_src2_o   ( rf_src2  ),
    .rf_src1_q_i ( rf_srcv1 ),
    .rf_src2_q_i ( rf_srcv2 ),
    .wb_we_i     ( wb_we    ),   // Bypass path
    .wb_dst_i    ( wb_dst   ),
    .wb_r_i      ( wb_r     ),
    .ex_wb_o     ( ex_wb    )
  );

  riscv_rf int_rf
  (
    .clk_i       ( clk_i    ),
    .rst_n_i     ( rst_n_i  ),
    .rf_src1_i   ( rf_src1  ),
    .rf_src2_i   ( rf_src2  ),
    .rf_src1_q_o ( rf_srcv1 ),
    .rf_src2_q_o ( rf_srcv2 ),
    .rf_dst_i    ( rf_dst   ),
    .rf_dst_d_i  ( rf_dst_d ),
    .rf_we_i     ( rf_we    )
  );

  riscv_wb wb_unit
  (
    .wb_i       ( ex_wb      ),
    .rf_dst_o   ( rf_dst     ),
    .rf_dst_d_o ( rf_dst_d   ),
    .rf_we_o    ( rf_we      ),
    .dmem_adr_o ( dmem_adr_o ),
    .dmem_d_o   ( dmem_d_o   ),
    .dmem_we_o  ( dmem_we_o  ),
    .wb_we_o    ( wb_we      ),
    .wb_dst_o   ( wb_dst     ),
    .wb_r_o     ( wb_r       )
  );

endmodule

// File: dv/tb_clk_gen.sv
// Testbench clock and power-on reset source, instantiated once by the testbench top
`timescale 1ns/10ps

module tb_clk_gen
(
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 5;    // 10 ns clock
  localparam int RESET_CYCLES = 16;

  initial
  begin
    clk_o = 1'b0;
    forever
      #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES)
      @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: dv/riscv_core_assert.sv
// Instruction bus, store strobe and reset assertions, bound into the core for simulation
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_core_assert
(
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic [`RISCV_XLEN-1:0] imem_adr_i,
  input logic                   imem_req_i,
  input logic                   imem_ack_i,
  input logic [`RISCV_XLEN-1:0] dmem_adr_i,
  input logic                   dmem_we_i
);

  //////////////////////////////
  // Reset behavior
  req_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !imem_req_i)
    else $error("Instruction request high while reset is asserted");

  store_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !dmem_we_i)
    else $error("Store strobe high while reset is asserted");

  req_after_release: assert property (@(posedge clk_i) $rose(rst_n_i) |=> imem_req_i)
    else $error("Instruction request not raised in the first cycle after reset");

  // First request goes out at the reset address
  first_fetch: assert property (@(posedge clk_i)
    $rose(imem_req_i) |-> rst_n_i && imem_adr_i == `RISCV_PC_INIT)
    else $error("First fetch not at the reset address, or request rose in reset");

  //////////////////////////////
  // Instruction bus protocol
  adr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    imem_req_i && !imem_ack_i |=> $stable(imem_adr_i))
    else $error("Fetch address changed while waiting for the acknowledge");

  adr_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    imem_req_i && imem_ack_i |=> imem_adr_i == $past(imem_adr_i) + 32'd4)
    else $error("Fetch address did not advance by 4 after an acknowledge");

  store_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dmem_we_i |-> dmem_adr_i[1:0] == 2'b00)
    else $error("Store address not word aligned");

endmodule

bind riscv_core riscv_core_assert core_assert
(
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .imem_adr_i ( imem_adr_o ),
  .imem_req_i ( imem_req_o ),
  .imem_ack_i ( imem_ack_i ),
  .dmem_adr_i ( dmem_adr_o ),
  .dmem_we_i  ( dmem_we_o  )
);

// File: dv/riscv_core_tb.sv
// Core testbench: random program in an instruction memory model, reference model and store checks
`timescale 1ns/10ps
`include "riscv_defines.svh"

module riscv_core_tb;

  localparam int N_INSN       = 200;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_NS   = N_INSN * 5 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
  localparam logic [31:0] NOP = 32'h0000_0013;   // ADDI x0, x0, 0

  typedef struct packed
  {
    logic [`RISCV_XLEN-1:0] adr;
    logic [`RISCV_XLEN-1:0] d;
  } store_t;

  logic                        clk, rst_n;
  logic [`RISCV_XLEN-1:0]      imem_adr, dmem_adr, dmem_d;
  logic                        imem_req, dmem_we;
  logic                        imem_ack = 1'b0;
  logic [`RISCV_INSN_BITS-1:0] imem_parcel = NOP;
  int                          wait_cnt = 0;    // Cycles left before the next acknowledge

  logic [`RISCV_INSN_BITS-1:0] prog [$];
  logic [`RISCV_XLEN-1:0]      ref_regs [32] = '{default: '0};
  store_t                      exp_stores [$];
  store_t                      exp_head;
  logic [`RISCV_REG_BITS-1:0]  last_rd = '0;

  tb_clk_gen clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  riscv_core dut
  (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .imem_adr_o    ( imem_adr    ),
    .imem_req_o    ( imem_req    ),
    .imem_ack_i    ( imem_ack    ),
    .imem_parcel_i ( imem_parcel ),
    .dmem_adr_o    ( dmem_adr    ),
    .dmem_d_o      ( dmem_d      ),
    .dmem_we_o     ( dmem_we     )
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [2:0] op_f3(input int kind);
    case (kind)
      2, 7:    return 3'b111;   // AND
      3, 8:    return 3'b110;   // OR
      4, 9:    return 3'b100;   // XOR
      default: return 3'b000;   // ADD and SUB
    endcase
  endfunction

  //////////////////////////////
  // Program generator with reference model
  task automatic add_store(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
    store_t st;
    prog.push_back({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011});
    st.adr = (ref_regs[rs1] + sext12(imm)) & 32'hffff_fffc;
    st.d   = ref_regs[rs2];
    exp_stores.push_back(st);
  endtask

  // Kind 0 LUI, 1..4 immediate ops, 5..9 register ops
  task automatic add_alu_op(input int kind);
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm;
    logic [19:0] imm_u;
    logic [31:0] a, b, res;
    logic [6:0]  f7;
    rd    = 5'($urandom % 8);
    rs1   = ($urandom % 2 != 0) ? last_rd : 5'($urandom % 8);   // Often the previous result
    rs2   = ($urandom % 2 != 0) ? last_rd : 5'($urandom % 8);
    imm   = 12'($urandom);
    imm_u = 20'($urandom);
    a     = ref_regs[rs1];
    b     = ref_regs[rs2];
    f7    = (kind == 6) ? 7'b0100000 : 7'b0000000;             // SUB
    case (kind)
      0:       res = {imm_u, 12'h000};
      1:       res = a + sext12(imm);
      2:       res = a & sext12(imm);
      3:       res = a | sext12(imm);
      4:       res = a ^ sext12(imm);
      5:       res = a + b;
      6:       res = a - b;
      7:       res = a & b;
      8:       res = a | b;
      default: res = a ^ b;
    endcase
    if (kind == 0)
      prog.push_back({imm_u, rd, 7'b0110111});
    else if (kind < 5)
      prog.push_back({imm, rs1, op_f3(kind), rd, 7'b0010011});
    else
      prog.push_back({f7, rs2, rs1, op_f3(kind), rd, 7'b0110011});
    if (rd != 0)
      ref_regs[rd] = res;
    last_rd = rd;
  endtask

  // Encodings outside the subset, none may touch a register or the bus
  task automatic add_unsupported();
    logic [4:0] rd, rs;
    rd = 5'($urandom % 8);
    rs = 5'($urandom % 8);
    case ($urandom % 4)
      0:       prog.push_back({12'h005, rs, 3'b001, rd, 7'b0010011});          // SLLI
      1:       prog.push_back({7'b0000001, rs, rs, 3'b000, rd, 7'b0110011});   // MUL
      2:       prog.push_back({7'h00, rs, rs, 3'b000, 5'h04, 7'b0100011});     // SB
      default: prog.push_back({12'h000, rs, 3'b010, rd, 7'b0000011});          // LW
    endcase
  endtask

  //////////////////////////////
  // Instruction memory model
  function automatic logic [31:0] fetch_word(input logic [31:0] adr);
    int idx;
    idx = int'((adr - `RISCV_PC_INIT) >> 2);
    if (adr >= `RISCV_PC_INIT && idx < prog.size())
      return prog[idx];
    return NOP;   // Past the end of the program
  endfunction

  always @(negedge clk)
  begin
    if (imem_req && wait_cnt == 0)
    begin
      imem_ack    <= 1'b1;
      imem_parcel <= fetch_word(imem_adr);
      wait_cnt    <= $urandom % 4;
    end
    else
    begin
      imem_ack <= 1'b0;
      if (wait_cnt != 0)
        wait_cnt <= wait_cnt - 1;
    end
  end

  initial
  begin
    int kind;
    void'($urandom(10));
    while (prog.size() < N_INSN)
    begin
      kind = int'($urandom % 12);
      if (kind < 10)
      begin
        add_alu_op(kind);
        if (prog.size() < N_INSN)
          add_store(last_rd, last_rd, 12'($urandom));   // Result just computed, as data and base
      end
      else if (kind == 10)
        add_unsupported();
      else
        add_store(5'($urandom % 8), 5'($urandom % 8), 12'($urandom));
    end

    // Strobes must come in program order
    while (exp_stores.size() != 0)
    begin
      @(negedge clk);
      if (dmem_we)
      begin
        exp_head = exp_stores.pop_front();
        store_adr: assert (dmem_adr == exp_head.adr)
          else abort_run($sformatf("Fail: dmem_adr_o expected %h got %h", exp_head.adr, dmem_adr));
        store_data: assert (dmem_d == exp_head.d)
          else abort_run($sformatf("Fail: dmem_d_o expected %h got %h", exp_head.d, dmem_d));
      end
    end

    // Drain the program tail
    while (imem_adr < `RISCV_PC_INIT + 4 * (N_INSN + 3))
    begin
      @(negedge clk);
      no_extra_store: assert (!dmem_we)
        else abort_run("Store strobe seen after the last SW instruction of the program");
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    abort_run("Timeout: the expected stores did not all complete");
  end

endmodule

// File: flist.f
+incdir+hdl
hdl/riscv_pkg.sv
hdl/riscv_if.sv
hdl/riscv_rf.sv
hdl/riscv_id_ex.sv
hdl/riscv_wb.sv
hdl/riscv_core.sv
dv/tb_clk_gen.sv
dv/riscv_core_assert.sv
dv/riscv_core_tb.sv

// File: Makefile
# Verilator build and run of the core testbench: make run, make clean
VERILATOR ?= verilator
TOP       ?= riscv_core_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
PASS_MSG  := *** TEST PASSED ***

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) hdl/riscv_defines.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
